// File: rtl/eg_pkg.sv
package eg_pkg;

    //////////////////// slot and level geometry
    localparam int EG_SLOTS     = 32;   // operator slots sharing the pipeline
    localparam int EG_SLOT_W    = 5;
    localparam int EG_LEVEL_W   = 10;
    localparam int EG_RATE_W    = 5;    // ar/d1r/d2r and key-scale amount
    localparam int EG_TIMECNT_W = 15;

    localparam logic [EG_LEVEL_W-1:0] EG_LEVEL_MAX      = 10'd1023; // quietest
    localparam logic [EG_LEVEL_W-1:0] EG_LEVEL_NEAR_MAX = 10'd1008; // 11_1111_xxxx
    localparam logic [5:0]            EG_SCALED_MAX     = 6'd63;
    localparam logic [EG_SLOT_W-1:0]  EG_LAST_SLOT      = EG_SLOT_W'(EG_SLOTS - 1);
    localparam logic [3:0]            EG_ATTEN_RATE_MAX = 4'd14;

    //////////////////// pipeline depth
    localparam int EG_UPD_DEPTH   = 4;  // ring read -> ring write
    localparam int EG_OUT_STAGES  = 3;  // am, tl, test force
    localparam int EG_OUT_LATENCY = EG_UPD_DEPTH + EG_OUT_STAGES;
    localparam int EG_RING_LEN    = EG_SLOTS - EG_UPD_DEPTH;

    // strong/weak delta weight, indexed by {scaled[1:0], envcntr}
    localparam logic [15:0] EG_INTENSITY_MAP = 16'h7510;

    typedef enum logic [1:0] {
        ATTACK       = 2'd0,
        FIRST_DECAY  = 2'd1,
        SECOND_DECAY = 2'd2,
        RELEASE      = 2'd3
    } eg_state_e;

    typedef enum logic [1:0] {
        AMS_OFF = 2'd0,
        AMS_X1  = 2'd1,
        AMS_X2  = 2'd2,
        AMS_X4  = 2'd3
    } eg_ams_e;

    // register data of the slot being sampled
    typedef struct packed {
        logic                 kon;
        logic [1:0]           ks;
        logic [EG_RATE_W-1:0] ar;
        logic [EG_RATE_W-1:0] d1r;
        logic [EG_RATE_W-1:0] d2r;
        logic [3:0]           rr;
        logic [3:0]           d1l;
        logic [6:0]           tl;
        eg_ams_e              ams;
    } eg_op_regs_t;

    typedef struct packed {
        logic       third_sample;
        logic [1:0] envcntr;
        logic [3:0] attenrate;   // 0..14
    } eg_rate_t;

    typedef struct packed {
        eg_state_e             state;
        logic [EG_LEVEL_W-1:0] level;
        logic                  kon_prev;
    } eg_slot_t;

    localparam eg_slot_t EG_SLOT_RESET = '{state: RELEASE, level: EG_LEVEL_MAX, kon_prev: 1'b0};

endpackage

// File: rtl/eg_rate_gen.sv
`timescale 1ns/1ps

module eg_rate_gen import eg_pkg::*; (
    input  logic                 i_EMUCLK,
    input  logic                 mrst_n,
    output logic [EG_SLOT_W-1:0] o_slot,
    output eg_rate_t             o_rate
);

    logic [EG_SLOT_W-1:0]    slot_cnt;
    logic [1:0]              sample_cnt;   // revolutions mod 3
    logic [EG_TIMECNT_W-1:0] timecntr;
    logic                    one_found;    // first set bit seen in this scan
    logic [3:0]              zero_cnt;     // consecutive zero bits, starts at 1
    logic                    scan_win;
    logic                    scan_bit;
    eg_rate_t                rate_q;

    //////////////////// slot and sample counters
    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) begin
            slot_cnt   <= '0;
            sample_cnt <= 2'd0;
        end else begin
            slot_cnt <= (slot_cnt == EG_LAST_SLOT) ? '0 : slot_cnt + 1'b1;
            if (slot_cnt == EG_LAST_SLOT) begin
                sample_cnt <= (sample_cnt == 2'd2) ? 2'd0 : sample_cnt + 2'd1;
            end
        end
    end

    //////////////////// zero run scan
    // slots 1..14 look at time counter bits 0..13, one per clock
    assign scan_win = (slot_cnt != '0) && (slot_cnt <= EG_SLOT_W'(EG_ATTEN_RATE_MAX));
    assign scan_bit = timecntr[4'(slot_cnt - 1'b1)];

    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n || slot_cnt == '0) begin
            one_found <= 1'b0;
            zero_cnt  <= 4'd1;
        end else if (scan_win && !one_found) begin
            if (scan_bit) begin
                one_found <= 1'b1;              // freeze the count
            end else if (zero_cnt == EG_ATTEN_RATE_MAX) begin
                zero_cnt <= 4'd0;               // all 14 bits zero -> rate 0
            end else begin
                zero_cnt <= zero_cnt + 4'd1;
            end
        end
    end

    //////////////////// time counter and rate latch
    // the next revolution is a third sample when sample_cnt moves to 2
    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) begin
            timecntr <= '0;
            rate_q   <= '0;
        end else if (slot_cnt == EG_LAST_SLOT) begin
            rate_q.third_sample <= (sample_cnt == 2'd1);
            if (sample_cnt == 2'd1) begin
                rate_q.attenrate <= zero_cnt;
                rate_q.envcntr   <= timecntr[2:1];
                timecntr         <= timecntr + 1'b1;   // one tick per third sample
            end
        end
    end

    assign o_slot = slot_cnt;
    assign o_rate = rate_q;

    // rate stays in table range
    a_rate_latch: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        rate_q.attenrate <= EG_ATTEN_RATE_MAX);

endmodule

// File: rtl/eg_slot_ring.sv
`timescale 1ns/1ps

module eg_slot_ring import eg_pkg::*; (
    input  logic     i_EMUCLK,
    input  logic     mrst_n,
    input  logic     i_kon,
    input  eg_slot_t i_wr,
    output eg_slot_t o_rd,
    output logic     o_kon_edge
);

    // ring plus the update pipeline makes exactly one revolution
    eg_slot_t ring [EG_RING_LEN];
    eg_slot_t head;

    //////////////////// storage loop
    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) begin
            for (int i = 0; i < EG_RING_LEN; i++) begin
                ring[i] <= EG_SLOT_RESET;     // release, quietest level
            end
        end else begin
            ring[0] <= i_wr;
            for (int i = 1; i < EG_RING_LEN; i++) begin
                ring[i] <= ring[i-1];
            end
        end
    end

    assign head = ring[EG_RING_LEN-1];

    //////////////////// key-on edge
    // previous kon came back with the record, one revolution old
    assign o_kon_edge = i_kon & ~head.kon_prev;

    always_comb begin
        o_rd = head;
        if (o_kon_edge) begin
            o_rd.state = ATTACK;   // new key-on restarts the envelope
        end
    end

    // kon_prev written back, so no edge for the same slot next revolution
    a_edge_once: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        o_kon_edge |-> ##EG_SLOTS !o_kon_edge);

endmodule

// File: rtl/eg_envelope_update.sv
`timescale 1ns/1ps

module eg_envelope_update import eg_pkg::*; (
    input  logic                  i_EMUCLK,
    input  logic                  mrst_n,
    input  eg_op_regs_t           i_op,
    input  logic [EG_RATE_W-1:0]  i_pdelta_shift,
    input  eg_rate_t              i_rate,
    input  eg_slot_t              i_rd,
    input  logic                  i_kon_edge,
    output eg_slot_t              o_wr,
    output logic [EG_LEVEL_W-1:0] o_level_new
);

    logic [EG_RATE_W-1:0]  egparam;
    logic [EG_RATE_W-1:0]  keyscale;
    logic [6:0]            scaled_sum;
    eg_state_e             s1_state;
    logic [EG_LEVEL_W-1:0] s1_level;
    logic                  s1_kon;
    logic                  s1_edge;
    logic [5:0]            s1_scaled;
    logic                  s1_param_zero;
    logic [3:0]            s1_d1l;
    logic                  prev_min;
    logic                  prev_max;
    logic                  d1_end;
    logic                  fullrate;
    logic                  intensity;
    logic [5:0]            rate_applied;
    eg_state_e             next_state;
    logic [3:0]            weight;
    eg_state_e             s2_state;
    logic                  s2_kon;
    logic [3:0]            s2_weight;
    logic                  s2_inc;
    logic                  s2_dec;
    logic                  s2_fix_max;
    logic                  s2_en_prev;
    logic [EG_LEVEL_W-1:0] s2_level;
    eg_state_e             s3_state;
    logic                  s3_kon;
    logic [EG_LEVEL_W-1:0] s3_gated;
    logic [EG_LEVEL_W-1:0] s3_delta;
    eg_state_e             s4_state;
    logic                  s4_kon;
    logic [EG_LEVEL_W-1:0] s4_level;

    //////////////////// stage 1: rate select, key scaling
    always_comb begin
        case (i_rd.state)
            ATTACK:       egparam = i_op.ar;
            FIRST_DECAY:  egparam = i_op.d1r;
            SECOND_DECAY: egparam = i_op.d2r;
            default:      egparam = {i_op.rr, 1'b0};   // rr is 4 bits
        endcase
        case (i_op.ks)
            2'd0:    keyscale = (egparam == '0) ? '0 : {3'b000, i_pdelta_shift[4:3]};
            2'd1:    keyscale = {2'b00, i_pdelta_shift[4:2]};
            2'd2:    keyscale = {1'b0, i_pdelta_shift[4:1]};
            default: keyscale = i_pdelta_shift;
        endcase
    end

    assign scaled_sum = {1'b0, egparam, 1'b0} + {2'b00, keyscale};

    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) begin
            s1_state <= RELEASE;
            s1_kon   <= 1'b0;
            s1_edge  <= 1'b0;
        end else begin
            s1_state <= i_rd.state;
            s1_kon   <= i_op.kon;
            s1_edge  <= i_kon_edge;
        end
        s1_level      <= i_rd.level;
        s1_scaled     <= scaled_sum[6] ? EG_SCALED_MAX : scaled_sum[5:0];   // sat at 63
        s1_param_zero <= (egparam == '0);
        s1_d1l        <= i_op.d1l;
    end

    //////////////////// stage 2: fsm, delta weight
    assign prev_min     = (s1_level == '0);
    assign prev_max     = (s1_level >= EG_LEVEL_NEAR_MAX);
    assign d1_end       = (s1_level[9:4] == {(s1_d1l == 4'd15), s1_d1l, 1'b0});
    assign fullrate     = (s1_scaled[5:1] == 5'b11111);   // instant attack
    assign intensity    = EG_INTENSITY_MAP[{s1_scaled[1:0], i_rate.envcntr}];
    assign rate_applied = s1_scaled + {i_rate.attenrate, 2'b00};   // carry dropped

    always_comb begin
        next_state = s1_state;
        if (s1_edge) begin
            next_state = ATTACK;
        end else if (!s1_kon) begin
            next_state = RELEASE;   // key off
        end else begin
            case (s1_state)
                ATTACK: begin
                    if (prev_min) next_state = FIRST_DECAY;
                end
                FIRST_DECAY: begin
                    if (prev_max)    next_state = RELEASE;
                    else if (d1_end) next_state = SECOND_DECAY;
                end
                SECOND_DECAY: begin
                    if (prev_max) next_state = RELEASE;
                end
                default: next_state = RELEASE;
            endcase
        end
    end

    // only every third sample moves the level
    always_comb begin
        weight = 4'b0000;
        if (i_rate.third_sample) begin
            case (s1_scaled[5:2])
                4'b1111: weight = 4'b1000;
                4'b1110: weight = intensity ? 4'b1000 : 4'b0100;
                4'b1101: weight = intensity ? 4'b0100 : 4'b0010;
                4'b1100: weight = intensity ? 4'b0010 : 4'b0001;
                default: begin
                    if (!s1_param_zero && s1_scaled != '0
                        && rate_applied inside {6'd48, 6'd49, 6'd50, 6'd51,
                                                6'd54, 6'd55, 6'd57, 6'd59}) begin
                        weight = 4'b0001;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) begin
            s2_state <= RELEASE;
            s2_kon   <= 1'b0;
            s2_inc   <= 1'b0;
            s2_dec   <= 1'b0;
        end else begin
            s2_state <= next_state;
            s2_kon   <= s1_kon;
            s2_inc   <= ~s1_edge & ~prev_max
                        & ((s1_state == FIRST_DECAY && !d1_end)
                           || s1_state == SECOND_DECAY || s1_state == RELEASE);
            s2_dec   <= (s1_state == ATTACK) & s1_kon & ~prev_min & ~fullrate;
        end
        s2_weight  <= weight;
        s2_fix_max <= (s1_state != ATTACK) & ~s1_edge & prev_max;
        s2_en_prev <= ~(s1_edge & fullrate);   // instant attack drops to 0
        s2_level   <= s1_level;
    end

    //////////////////// stage 3: gate previous level, weighted delta
    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) begin
            s3_state <= RELEASE;
            s3_kon   <= 1'b0;
        end else begin
            s3_state <= s2_state;
            s3_kon   <= s2_kon;
        end
        if (!mrst_n || s2_fix_max) s3_gated <= EG_LEVEL_MAX;
        else                       s3_gated <= s2_en_prev ? s2_level : '0;
        case ({s2_dec, s2_inc})
            2'b01: s3_delta <= {6'b000000, s2_weight};   // quieter
            2'b10: begin                                   // louder, scaled by level
                case (s2_weight)
                    4'b0001: s3_delta <= {4'b1111, ~s2_level[9:5], ~s2_level[3]};
                    4'b0010: s3_delta <= {3'b111, ~s2_level[9:5], ~s2_level[3], ~s2_level[1]};
                    4'b0100: s3_delta <= {2'b11, ~s2_level[9:5], ~s2_level[3],
                                          {2{~s2_level[2]}}};
                    4'b1000: s3_delta <= {1'b1, ~s2_level[9:5], {4{~s2_level[4]}}};
                    default: s3_delta <= '0;
                endcase
            end
            default: s3_delta <= '0;
        endcase
    end

    //////////////////// stage 4: level add
    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) begin
            s4_state <= RELEASE;
            s4_kon   <= 1'b0;
        end else begin
            s4_state <= s3_state;
            s4_kon   <= s3_kon;
        end
        s4_level <= s3_gated + s3_delta;   // wraps, attack delta is negative
    end

    assign o_wr        = '{state: s4_state, level: s4_level, kon_prev: s4_kon};
    assign o_level_new = s4_level;

    a_inc_dec_excl: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        !(s2_inc && s2_dec));

endmodule

// File: rtl/eg_level_out.sv
`timescale 1ns/1ps

module eg_level_out import eg_pkg::*; (
    input  logic                  i_EMUCLK,
    input  logic [EG_LEVEL_W-1:0] i_level,
    input  logic [6:0]            i_tl,
    input  eg_ams_e               i_ams,
    input  logic [7:0]            i_lfa,
    input  logic                  i_force_min,
    output logic [EG_LEVEL_W-1:0] o_atten
);

    logic [EG_LEVEL_W-1:0] lfa_shifted;
    logic [EG_LEVEL_W:0]   mod_sum;
    logic [EG_LEVEL_W-1:0] mod_q;
    logic [6:0]            tl_q;
    logic [EG_LEVEL_W:0]   tl_sum;
    logic [EG_LEVEL_W-1:0] tl_level_q;
    logic [EG_LEVEL_W-1:0] atten_q;

    //////////////////// amplitude modulation
    always_comb begin
        case (i_ams)
            AMS_OFF: lfa_shifted = '0;
            AMS_X1:  lfa_shifted = {2'b00, i_lfa};
            AMS_X2:  lfa_shifted = {1'b0, i_lfa, 1'b0};
            default: lfa_shifted = {i_lfa, 2'b00};
        endcase
    end

    assign mod_sum = {1'b0, i_level} + {1'b0, lfa_shifted};

    always_ff @(posedge i_EMUCLK) begin
        mod_q <= mod_sum[EG_LEVEL_W] ? EG_LEVEL_MAX : mod_sum[EG_LEVEL_W-1:0];
        tl_q  <= i_tl;
    end

    //////////////////// total level
    assign tl_sum = {1'b0, mod_q} + {1'b0, tl_q, 3'b000};   // tl x 8

    always_ff @(posedge i_EMUCLK) begin
        tl_level_q <= tl_sum[EG_LEVEL_W] ? EG_LEVEL_MAX : tl_sum[EG_LEVEL_W-1:0];
    end

    //////////////////// test force
    always_ff @(posedge i_EMUCLK) begin
        atten_q <= i_force_min ? '0 : tl_level_q;   // loudest
    end

    assign o_atten = atten_q;

endmodule

// File: rtl/eg_top.sv
`timescale 1ns/1ps

module eg_top import eg_pkg::*; (
    input  logic                  i_EMUCLK,
    input  logic                  mrst_n,
    input  eg_op_regs_t           i_op,
    input  logic [EG_RATE_W-1:0]  i_pdelta_shift,
    input  logic [7:0]            i_lfa,
    input  logic                  i_force_min,
    output logic [EG_SLOT_W-1:0]  o_in_slot,
    output logic [EG_SLOT_W-1:0]  o_out_slot,
    output logic                  o_phase_rst,
    output logic [EG_LEVEL_W-1:0] o_atten
);

    logic [EG_SLOT_W-1:0]      slot;
    eg_rate_t                  rate;
    eg_slot_t                  rd;
    eg_slot_t                  wr;
    logic                      kon_edge;
    logic [EG_LEVEL_W-1:0]     level_new;
    logic [EG_SLOT_W-1:0]      slot_dly [EG_OUT_LATENCY];
    logic [EG_OUT_LATENCY-1:0] edge_dly;
    eg_op_regs_t               op_dly [EG_UPD_DEPTH];   // tl/ams follow the level

    eg_rate_gen u_rate_gen (
        .i_EMUCLK (i_EMUCLK),
        .mrst_n   (mrst_n),
        .o_slot   (slot),
        .o_rate   (rate)
    );

    eg_slot_ring u_slot_ring (
        .i_EMUCLK   (i_EMUCLK),
        .mrst_n     (mrst_n),
        .i_kon      (i_op.kon),
        .i_wr       (wr),
        .o_rd       (rd),
        .o_kon_edge (kon_edge)
    );

    eg_envelope_update u_envelope_update (
        .i_EMUCLK       (i_EMUCLK),
        .mrst_n         (mrst_n),
        .i_op           (i_op),
        .i_pdelta_shift (i_pdelta_shift),
        .i_rate         (rate),
        .i_rd           (rd),
        .i_kon_edge     (kon_edge),
        .o_wr           (wr),
        .o_level_new    (level_new)
    );

    eg_level_out u_level_out (
        .i_EMUCLK    (i_EMUCLK),
        .i_level     (level_new),
        .i_tl        (op_dly[EG_UPD_DEPTH-1].tl),
        .i_ams       (op_dly[EG_UPD_DEPTH-1].ams),
        .i_lfa       (i_lfa),
        .i_force_min (i_force_min),
        .o_atten     (o_atten)
    );

    //////////////////// slot tag delay to the output side
    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) edge_dly <= '0;
        else         edge_dly <= {edge_dly[EG_OUT_LATENCY-2:0], kon_edge};
        slot_dly[0] <= slot;
        for (int i = 1; i < EG_OUT_LATENCY; i++) begin
            slot_dly[i] <= slot_dly[i-1];
        end
        op_dly[0] <= i_op;
        for (int i = 1; i < EG_UPD_DEPTH; i++) begin
            op_dly[i] <= op_dly[i-1];
        end
    end

    assign o_in_slot   = slot;
    assign o_out_slot  = slot_dly[EG_OUT_LATENCY-1];
    assign o_phase_rst = edge_dly[EG_OUT_LATENCY-1];

endmodule

// File: test/tb_eg_top.sv
`timescale 1ns/1ps

module tb_eg_top import eg_pkg::*; ();

    localparam string VEC_FILE      = "test/eg_vectors.txt";
    localparam int    RESET_CYCLES  = 16;
    localparam int    MARGIN_CYCLES = 64;

    // one line of the vector file
    typedef struct packed {
        eg_op_regs_t          op;          // kon filled in per slot from mask
        logic [EG_RATE_W-1:0] shift;
        logic [7:0]           lfa;
        logic                 force_min;
        logic [EG_SLOTS-1:0]  mask;
        int                   revs;        // run length in revolutions
        int                   exp_keyed;   // settled o_atten of a keyed slot
    } vec_t;

    logic                  emuclk;
    logic                  mrst_n;
    eg_op_regs_t           op;
    logic [EG_RATE_W-1:0]  pdelta_shift;
    logic [7:0]            lfa;
    logic                  force_min;
    logic [EG_SLOT_W-1:0]  in_slot;
    logic [EG_SLOT_W-1:0]  out_slot;
    logic                  phase_rst;
    logic [EG_LEVEL_W-1:0] atten;

    vec_t                vecs [$];
    string               names [$];
    logic [EG_SLOTS-1:0] prev_mask;     // key-on mask of the previous test
    int                  exp_in_slot  = 0;   // slot counter model, 0 at reset
    int                  vec_errors   = 0;
    int                  total_errors = 0;
    int                  tests_failed = 0;
    int                  cycles       = 0;
    int                  cycle_limit  = 0;

    eg_top eg_top_i (
        .i_EMUCLK       (emuclk),
        .mrst_n         (mrst_n),
        .i_op           (op),
        .i_pdelta_shift (pdelta_shift),
        .i_lfa          (lfa),
        .i_force_min    (force_min),
        .o_in_slot      (in_slot),
        .o_out_slot     (out_slot),
        .o_phase_rst    (phase_rst),
        .o_atten        (atten)
    );

    //////////////////// clock and watchdog
    initial begin
        emuclk = 1'b0;
        forever #2 emuclk = ~emuclk;   // 4 ns period
    end

    always @(posedge emuclk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("tests failed");
            $finish;
        end
    end

    //////////////////// reference rules
    // settled output once attack is instant and both decay rates are zero
    function automatic int settled_atten(bit keyed, bit frc, int tl, int ams, int lfa_val);
        int sum;
        if (frc) return 0;                  // test bit forces loudest
        if (!keyed) return 1023;            // released slot sits at the top
        sum = (ams == 0) ? 0 : (lfa_val << (ams - 1));
        sum = sum + tl * 8;
        return (sum > 1023) ? 1023 : sum;
    endfunction

    // one falling edge, slot counter model moves along
    task automatic advance_cycle();
        @(negedge emuclk);
        exp_in_slot = (exp_in_slot + 1) % EG_SLOTS;
    endtask

    task automatic read_vectors();
        int          fd;
        int          n;
        int          ks, ar, d1r, d2r, rr, d1l, tl, ams, shift, lfa_v, frc, revs, expv;
        logic [31:0] mask;
        string       line;
        string       name;
        vec_t        v;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s", VEC_FILE);
            vec_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %h %d %h %d %d", name,
                            ks, ar, d1r, d2r, rr, d1l, tl, ams, shift, lfa_v, frc, mask,
                            revs, expv);
                if (n != 15 || revs < 2) begin
                    $display("bad vector line, needs 15 fields and 2+ revolutions: %s", line);
                    vec_errors++;
                end else begin
                    v = '0;
                    v.op.ks  = 2'(ks);
                    v.op.ar  = 5'(ar);
                    v.op.d1r = 5'(d1r);
                    v.op.d2r = 5'(d2r);
                    v.op.rr  = 4'(rr);
                    v.op.d1l = 4'(d1l);
                    v.op.tl  = 7'(tl);
                    v.op.ams = eg_ams_e'(2'(ams));
                    v.shift     = 5'(shift);
                    v.lfa       = 8'(lfa_v);
                    v.force_min = frc[0];
                    v.mask      = mask;
                    v.revs      = revs;
                    v.exp_keyed = expv;
                    vecs.push_back(v);
                    names.push_back(name);
                end
            end
        end
        $fclose(fd);
    endtask

    //////////////////// one test
    task automatic run_test(input int idx);
        vec_t                v;
        int                  errs;
        int                  rule_keyed;
        int                  exp_val;
        int                  slot;
        int                  prev_out;
        int                  got;
        int                  pulses [EG_SLOTS];
        int                  last_val [EG_SLOTS];
        bit                  seen [EG_SLOTS];
        logic [EG_SLOTS-1:0] rose;
        logic [EG_SLOTS-1:0] fell;
        v = vecs[idx];
        errs = 0;
        prev_out = 0;
        rose = v.mask & ~prev_mask;         // these must pulse once
        fell = prev_mask & ~v.mask;         // these release, never louder
        rule_keyed = settled_atten(1'b1, v.force_min, int'(v.op.tl), int'(v.op.ams),
                                   int'(v.lfa));
        if (rule_keyed != v.exp_keyed) begin
            $display("test %s: vector value %0d for keyed slots does not match the rules (%0d)",
                     names[idx], v.exp_keyed, rule_keyed);
            errs++;
        end
        for (int i = 0; i < EG_SLOTS; i++) begin
            pulses[i] = 0;
            last_val[i] = 0;
            seen[i] = 1'b0;
        end
        pdelta_shift = v.shift;
        lfa = v.lfa;
        force_min = v.force_min;
        for (int rev = 0; rev < v.revs; rev++) begin
            for (int c = 0; c < EG_SLOTS; c++) begin
                advance_cycle();
                slot = int'(out_slot);      // outputs are registered, stable here
                got = int'(atten);
                if (int'(in_slot) != exp_in_slot) begin
                    $display("CHECK FAILED %s o_in_slot: expected %0d, actual %0d",
                             names[idx], exp_in_slot, in_slot);
                    errs++;
                end
                // output tag steps one slot per clock
                if ((rev > 0 || c > 0) && slot != (prev_out + 1) % EG_SLOTS) begin
                    $display("CHECK FAILED %s o_out_slot: expected %0d, actual %0d",
                             names[idx], (prev_out + 1) % EG_SLOTS, slot);
                    errs++;
                end
                prev_out = slot;
                if (phase_rst) begin
                    pulses[slot] = pulses[slot] + 1;
                end
                // first revolution still carries outputs of the previous test
                if (rev > 0 && fell[slot]) begin
                    if (seen[slot] && got < last_val[slot]) begin
                        $display("test %s slot %0d: attenuation dropped from %0d to %0d",
                                 names[idx], slot, last_val[slot], got);
                        errs++;
                    end
                    last_val[slot] = got;
                    seen[slot] = 1'b1;
                end
                if (rev == v.revs - 1) begin
                    exp_val = settled_atten(v.mask[slot], v.force_min, int'(v.op.tl),
                                            int'(v.op.ams), int'(v.lfa));
                    if (got != exp_val) begin
                        $display("CHECK FAILED %s slot %0d o_atten: expected %0d, actual %0d",
                                 names[idx], slot, exp_val, got);
                        errs++;
                    end
                end
                op = v.op;
                op.kon = v.mask[in_slot];   // register data for the next sampled slot
            end
        end
        for (int i = 0; i < EG_SLOTS; i++) begin
            if (pulses[i] != int'(rose[i])) begin
                $display("CHECK FAILED %s slot %0d phase reset pulses: expected %0d, actual %0d",
                         names[idx], i, int'(rose[i]), pulses[i]);
                errs++;
            end
        end
        if (errs == 0) begin
            $display("test %s: ok", names[idx]);
        end else begin
            $display("test %s: FAILED with %0d errors", names[idx], errs);
            tests_failed++;
        end
        total_errors += errs;
        prev_mask = v.mask;
    endtask

    //////////////////// sequence
    initial begin
        mrst_n = 1'b0;
        op = '0;
        pdelta_shift = '0;
        lfa = '0;
        force_min = 1'b0;
        prev_mask = '0;
        read_vectors();
        if (vec_errors != 0 || vecs.size() == 0) begin
            $display("no usable test vectors in %s", VEC_FILE);
            $display("tests failed");
        end else begin
            cycle_limit = RESET_CYCLES + EG_SLOTS + EG_OUT_LATENCY + MARGIN_CYCLES;
            foreach (vecs[i]) begin
                cycle_limit += vecs[i].revs * EG_SLOTS;
            end
            repeat (RESET_CYCLES) @(negedge emuclk);
            mrst_n = 1'b1;
            exp_in_slot = 0;
            repeat (EG_SLOTS) advance_cycle();   // one revolution to settle the ring
            foreach (vecs[i]) begin
                run_test(i);
            end
            $display("%0d run, %0d passed, %0d failed, %0d errors", vecs.size(),
                     vecs.size() - tests_failed, tests_failed, total_errors);
            if (tests_failed == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
        end
        $finish;
    end

endmodule

// File: test/eg_vectors.txt
# name ks ar d1r d2r rr d1l tl ams shift lfa(hex) force kon_mask(hex) revolutions exp_keyed
# exp_keyed is the settled o_atten of a keyed slot, unkeyed slots settle at 1023
reset_idle     3 31 0 0 15 0   0 0 31 00 0 00000000   2    0
attack_instant 3 31 0 0 15 0  16 0 31 00 0 842100f1   3  128
attack_tl_max  3 31 0 0 15 0 127 0 31 00 0 842100f1   2 1016
ams_x1         3 31 0 0 15 0  16 1 31 5a 0 842100f1   2  218
ams_x2         3 31 0 0 15 0  16 2 31 40 0 842100f1   2  256
ams_x4_sat     3 31 0 0 15 0  40 3 31 c8 0 842100f1   2 1023
ams_off        3 31 0 0 15 0  16 0 31 ff 0 842100f1   2  128
release_rr15   3 31 0 0 15 0   0 0 31 00 0 00000000 400    0
phase_rise     3 31 0 0 15 0   8 0 31 00 0 0000ffff   3   64
phase_more     3 31 0 0 15 0   8 0 31 00 0 ffffffff   3   64
force_min      3 31 0 0 15 0 100 3 31 ff 1 ffffffff   2    0

// File: ym_eg.f
rtl/eg_pkg.sv
rtl/eg_rate_gen.sv
rtl/eg_slot_ring.sv
rtl/eg_envelope_update.sv
rtl/eg_level_out.sv
rtl/eg_top.sv
test/tb_eg_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing -j 0
TOP       ?= tb_eg_top
FILELIST  ?= ym_eg.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
